// File: verilog.f
hw/issue_pkg.sv
hw/inst_decoder.sv
hw/issue_queue.sv
hw/issue_ctrl.sv
hw/reg_file.sv
hw/issue_stage.sv
dv/tb_issue_stage.sv

// File: Bender.yml
package:
  name: issue_stage

sources:
  - files:
      - hw/issue_pkg.sv
      - hw/inst_decoder.sv
      - hw/issue_queue.sv
      - hw/issue_ctrl.sv
      - hw/reg_file.sv
      - hw/issue_stage.sv
  - target: simulation
    files:
      - dv/tb_issue_stage.sv

// File: dv/tb_issue_stage.sv
`default_nettype none

module tb_issue_stage import issue_pkg::*; ();

    localparam int HALF_PERIOD  = 4;
    localparam int SAMPLE_DLY   = 2;  // mid low phase, outputs settled
    localparam int RESET_CYCLES = 5;
    // reset, then the six tests with worst case drains
    localparam int TEST_CYCLES    = 6 + 12 + 2 + 11 + 19 + 6 + 2;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic            clk;
    logic            rstn;
    logic [1:0]      i_fetch_valid;
    logic [XLEN-1:0] i_fetch_pc0;
    logic [XLEN-1:0] i_fetch_pc1;
    logic [31:0]     i_fetch_inst0;
    logic [31:0]     i_fetch_inst1;
    logic            o_iq_full;
    logic            i_flush;
    logic            i_stall;
    logic [1:0]      i_wb_we;
    logic [4:0]      i_wb_addr0;
    logic [4:0]      i_wb_addr1;
    logic [XLEN-1:0] i_wb_data0;
    logic [XLEN-1:0] i_wb_data1;
    logic [1:0]      o_iss_valid;
    logic [XLEN-1:0] o_iss_pc_a;
    logic [XLEN-1:0] o_iss_pc_b;
    op_class_e       o_iss_cls_a;
    op_class_e       o_iss_cls_b;
    alu_fn_e         o_iss_alu_fn_a;
    alu_fn_e         o_iss_alu_fn_b;
    logic [4:0]      o_iss_rd_a;
    logic [4:0]      o_iss_rd_b;
    logic            o_iss_we_a;
    logic            o_iss_we_b;
    logic [XLEN-1:0] o_iss_imm_a;
    logic [XLEN-1:0] o_iss_imm_b;
    logic [XLEN-1:0] o_iss_src1_a;
    logic [XLEN-1:0] o_iss_src1_b;
    logic [XLEN-1:0] o_iss_src2_a;
    logic [XLEN-1:0] o_iss_src2_b;

    // values for the next falling edge
    logic [1:0]      nxt_fetch_valid;
    logic [31:0]     nxt_inst0;
    logic [31:0]     nxt_inst1;
    logic            nxt_stall;
    logic            nxt_flush;
    logic [1:0]      nxt_wb_we;
    logic [4:0]      nxt_wb_addr0;
    logic [4:0]      nxt_wb_addr1;
    logic [XLEN-1:0] nxt_wb_data0;
    logic [XLEN-1:0] nxt_wb_data1;

    // reference model
    dec_pkt_t        exp_q[$];      // queued packets, oldest first
    logic [XLEN-1:0] model_regs [NREG];
    logic [XLEN-1:0] pc_next;
    int              last_issue;    // count the DUT issued in the last cycle
    int              cycle_cnt;
    int unsigned     seed;

    issue_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    ////////////////////
    // failure, timeout
    ////////////////////

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: time %0t, %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    ////////////////////
    // encoding, model
    ////////////////////

    function automatic logic [31:0] enc_rr(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {op, rd, rj, rk, 13'd0};
    endfunction

    function automatic logic [31:0] enc_ri(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [15:0] imm);
        return {op, rd, rj, 2'b00, imm};
    endfunction

    // what the decoder should make of one word
    function automatic dec_pkt_t predict_pkt(input logic [31:0] inst, input logic [31:0] pc);
        dec_pkt_t p;
        p.pc       = pc;
        p.cls      = cls_nop;
        p.alu_fn   = fn_add;
        p.rd       = 5'd0;
        p.rs1      = inst[22:18];   // always rj
        p.rs2      = 5'd0;
        p.imm      = {{16{inst[15]}}, inst[15:0]};
        p.rf_we    = 1'b0;
        p.uses_rs2 = 1'b0;
        case (inst[31:28])
            4'd1, 4'd2, 4'd3, 4'd4: begin
                p.cls      = cls_alu;
                p.alu_fn   = alu_fn_e'(2'(inst[31:28] - 4'd1)); // add, sub, and, or
                p.rf_we    = 1'b1;
                p.rs2      = inst[17:13];
                p.uses_rs2 = 1'b1;
            end
            4'd5: begin
                p.cls   = cls_alu_imm;
                p.rf_we = 1'b1;
            end
            4'd6: begin
                p.cls   = cls_load;
                p.rf_we = 1'b1;
            end
            4'd7, 4'd8: begin
                p.cls      = (inst[31:28] == 4'd7) ? cls_store : cls_branch;
                p.rs2      = inst[27:23]; // data or compare register
                p.uses_rs2 = 1'b1;
            end
            default: p.cls = cls_nop;
        endcase
        if (p.rf_we) p.rd = inst[27:23];
        return p;
    endfunction

    function automatic int expected_issue_num();
        dec_pkt_t a;
        dec_pkt_t b;
        logic     both_mem;
        logic     raw;
        if (exp_q.size() == 0 || i_stall) return 0;
        if (exp_q.size() == 1) return 1;
        a = exp_q[0];
        b = exp_q[1];
        both_mem = (a.cls inside {cls_load, cls_store}) && (b.cls inside {cls_load, cls_store});
        raw = a.rf_we && (a.rd != 5'd0)
              && ((b.rs1 == a.rd) || (b.uses_rs2 && (b.rs2 == a.rd)));
        if ((a.cls == cls_branch) || both_mem || raw) return 1;
        return 2;
    endfunction

    ////////////////////
    // cycle driver
    ////////////////////

    task automatic check_slot(input string s, input dec_pkt_t e, input logic [31:0] pc,
                              input op_class_e cls, input alu_fn_e fn, input logic [4:0] rd,
                              input logic we, input logic [31:0] imm,
                              input logic [31:0] src1, input logic [31:0] src2);
        compare_value({"o_iss_pc_", s}, pc, e.pc);
        compare_value({"o_iss_cls_", s}, cls, e.cls);
        if (e.cls == cls_alu) compare_value({"o_iss_alu_fn_", s}, fn, e.alu_fn);
        compare_value({"o_iss_rd_", s}, rd, e.rd);
        compare_value({"o_iss_we_", s}, we, e.rf_we);
        compare_value({"o_iss_imm_", s}, imm, e.imm);
        compare_value({"o_iss_src1_", s}, src1, model_regs[e.rs1]);
        if (e.uses_rs2) compare_value({"o_iss_src2_", s}, src2, model_regs[e.rs2]);
    endtask

    task automatic run_cycle();
        int         n;
        logic [1:0] exp_valid;
        @(negedge clk);
        i_fetch_valid = nxt_fetch_valid;
        i_fetch_inst0 = nxt_inst0;
        i_fetch_inst1 = nxt_inst1;
        i_fetch_pc0   = pc_next;
        i_fetch_pc1   = pc_next + 32'd4;
        i_stall       = nxt_stall;
        i_flush       = nxt_flush;
        i_wb_we       = nxt_wb_we;
        i_wb_addr0    = nxt_wb_addr0;
        i_wb_addr1    = nxt_wb_addr1;
        i_wb_data0    = nxt_wb_data0;
        i_wb_data1    = nxt_wb_data1;
        #SAMPLE_DLY;
        n = expected_issue_num();
        exp_valid = (n == 2) ? 2'b11 : ((n == 1) ? 2'b01 : 2'b00);
        compare_value("o_iss_valid", o_iss_valid, exp_valid);
        compare_value("o_iq_full", o_iq_full, exp_q.size() >= IQ_DEPTH - IQ_FULL_MARGIN);
        if (n >= 1) begin
            check_slot("a", exp_q[0], o_iss_pc_a, o_iss_cls_a, o_iss_alu_fn_a, o_iss_rd_a,
                       o_iss_we_a, o_iss_imm_a, o_iss_src1_a, o_iss_src2_a);
        end
        if (n == 2) begin
            check_slot("b", exp_q[1], o_iss_pc_b, o_iss_cls_b, o_iss_alu_fn_b, o_iss_rd_b,
                       o_iss_we_b, o_iss_imm_b, o_iss_src1_b, o_iss_src2_b);
        end
        last_issue = int'(o_iss_valid[0]) + int'(o_iss_valid[1]);
        // model state after the coming rising edge
        repeat (n) void'(exp_q.pop_front());
        if (i_flush) begin
            exp_q.delete();
        end else begin
            if (i_fetch_valid[0]) exp_q.push_back(predict_pkt(i_fetch_inst0, i_fetch_pc0));
            if (i_fetch_valid[1]) exp_q.push_back(predict_pkt(i_fetch_inst1, i_fetch_pc1));
        end
        if (i_wb_we[0] && (i_wb_addr0 != 5'd0)) model_regs[i_wb_addr0] = i_wb_data0;
        if (i_wb_we[1] && (i_wb_addr1 != 5'd0)) model_regs[i_wb_addr1] = i_wb_data1;
        pc_next = pc_next + (i_fetch_valid[1] ? 32'd8 : (i_fetch_valid[0] ? 32'd4 : 32'd0));
        nxt_fetch_valid = 2'b00;
        nxt_wb_we       = 2'b00;
        nxt_flush       = 1'b0;
    endtask

    task automatic stage_fetch(input logic [1:0] v, input logic [31:0] i0,
                               input logic [31:0] i1);
        nxt_fetch_valid = v;
        nxt_inst0       = i0;
        nxt_inst1       = i1;
    endtask

    task automatic write_back(input logic [4:0] a0, input logic [4:0] a1);
        nxt_wb_we    = 2'b11;
        nxt_wb_addr0 = a0;
        nxt_wb_addr1 = a1;
        nxt_wb_data0 = $urandom();
        nxt_wb_data1 = $urandom();
        run_cycle();
    endtask

    task automatic expect_issue_count(input int n);
        compare_value("issue count on o_iss_valid", last_issue, n);
    endtask

    task automatic drain_queue();
        while (exp_q.size() != 0) begin
            run_cycle();
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic reset_and_regfile();
        repeat (2) run_cycle();     // idle, nothing valid, not full
        write_back(5'd1, 5'd2);
        write_back(5'd3, 5'd4);
        write_back(5'd5, 5'd6);
        write_back(5'd7, 5'd8);
        write_back(5'd9, 5'd9);     // same target, port 1 kept
        write_back(5'd0, 5'd10);    // x0 stays zero
        stage_fetch(2'b11, enc_rr(op_add, 5'd11, 5'd1, 5'd2), enc_rr(op_sub, 5'd12, 5'd3, 5'd4));
        run_cycle();
        stage_fetch(2'b11, enc_rr(op_or, 5'd13, 5'd0, 5'd9), enc_rr(op_and, 5'd14, 5'd10, 5'd5));
        run_cycle();
        expect_issue_count(2);
        stage_fetch(2'b11, enc_rr(op_sub, 5'd15, 5'd6, 5'd7),
                    enc_ri(op_store, 5'd8, 5'd0, 16'h0020));
        run_cycle();
        drain_queue();
    endtask

    task automatic independent_pair();
        stage_fetch(2'b11, enc_rr(op_add, 5'd16, 5'd1, 5'd2),
                    enc_ri(op_addi, 5'd17, 5'd3, 16'h8004)); // negative imm
        run_cycle();
        run_cycle();
        expect_issue_count(2);
    endtask

    task automatic check_pair(input logic [31:0] i0, input logic [31:0] i1, input int first);
        stage_fetch(2'b11, i0, i1);
        run_cycle();
        run_cycle();
        expect_issue_count(first);
        drain_queue();
    endtask

    task automatic pairing_limits();
        check_pair(enc_rr(op_add, 5'd18, 5'd1, 5'd2), enc_rr(op_sub, 5'd19, 5'd18, 5'd3), 1);
        check_pair(enc_ri(op_store, 5'd4, 5'd1, 16'h0010),
                   enc_ri(op_load, 5'd20, 5'd2, 16'hfff8), 1);
        check_pair(enc_ri(op_beq, 5'd1, 5'd2, 16'h0040), enc_rr(op_add, 5'd21, 5'd3, 5'd4), 1);
        // write after write only, no read of a's rd
        check_pair(enc_rr(op_add, 5'd22, 5'd1, 5'd2),
                   enc_ri(op_addi, 5'd22, 5'd5, 16'h0007), 2);
    endtask

    task automatic stall_fill_drain();
        logic [31:0] word0;
        logic [31:0] word1;
        nxt_stall = 1'b1;
        while (exp_q.size() < IQ_DEPTH - IQ_FULL_MARGIN) begin
            word0 = {4'($urandom_range(8, 1)), 28'($urandom())};
            word1 = {4'($urandom_range(8, 1)), 28'($urandom())};
            stage_fetch(2'b11, word0, word1);
            run_cycle();
        end
        run_cycle();                // held with nothing fetched
        compare_value("o_iq_full", o_iq_full, 1'b1);
        nxt_stall = 1'b0;
        drain_queue();
    endtask

    task automatic flush_queue();
        nxt_stall = 1'b1;
        stage_fetch(2'b11, enc_rr(op_add, 5'd23, 5'd1, 5'd2), enc_rr(op_add, 5'd24, 5'd3, 5'd4));
        run_cycle();
        stage_fetch(2'b11, enc_rr(op_sub, 5'd23, 5'd5, 5'd6), enc_rr(op_or, 5'd24, 5'd7, 5'd8));
        run_cycle();
        nxt_flush = 1'b1;
        stage_fetch(2'b11, enc_rr(op_and, 5'd25, 5'd1, 5'd1), enc_rr(op_and, 5'd26, 5'd2, 5'd2));
        run_cycle();                // same-cycle fetch dropped
        nxt_stall = 1'b0;
        stage_fetch(2'b11, enc_rr(op_or, 5'd25, 5'd5, 5'd6),
                    enc_ri(op_addi, 5'd26, 5'd7, 16'h1234));
        run_cycle();
        expect_issue_count(0);
        run_cycle();
        expect_issue_count(2);
    endtask

    task automatic undefined_opcodes();
        stage_fetch(2'b11, {4'hb, 5'd27, 5'd1, 18'h2a5a5}, {4'hf, 5'd28, 5'd2, 18'h3ffff});
        run_cycle();
        run_cycle();
        expect_issue_count(2);
        compare_value("o_iss_we_a", o_iss_we_a, 1'b0);
        compare_value("o_iss_we_b", o_iss_we_b, 1'b0);
    endtask

    ////////////////////
    // main
    ////////////////////

    initial begin
        seed = 32'h9a1c_1cc2;
        void'($urandom(seed));
        cycle_cnt       = 0;
        last_issue      = 0;
        rstn            = 1'b0;
        i_fetch_valid   = 2'b00;
        i_fetch_pc0     = '0;
        i_fetch_pc1     = '0;
        i_fetch_inst0   = '0;
        i_fetch_inst1   = '0;
        i_flush         = 1'b0;
        i_stall         = 1'b0;
        i_wb_we         = 2'b00;
        i_wb_addr0      = '0;
        i_wb_addr1      = '0;
        i_wb_data0      = '0;
        i_wb_data1      = '0;
        nxt_fetch_valid = 2'b00;
        nxt_inst0       = '0;
        nxt_inst1       = '0;
        nxt_stall       = 1'b0;
        nxt_flush       = 1'b0;
        nxt_wb_we       = 2'b00;
        nxt_wb_addr0    = '0;
        nxt_wb_addr1    = '0;
        nxt_wb_data0    = '0;
        nxt_wb_data1    = '0;
        pc_next         = 32'h0000_1000;
        exp_q.delete();
        for (int i = 0; i < NREG; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        reset_and_regfile();
        independent_pair();
        pairing_limits();
        stall_fill_drain();
        flush_queue();
        undefined_opcodes();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/issue_stage.sv
`default_nettype none

module issue_stage import issue_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    // front end
    input  logic [1:0]      i_fetch_valid,
    input  logic [XLEN-1:0] i_fetch_pc0,
    input  logic [XLEN-1:0] i_fetch_pc1,
    input  logic [31:0]     i_fetch_inst0,
    input  logic [31:0]     i_fetch_inst1,
    output logic            o_iq_full,
    // pipeline control
    input  logic            i_flush,
    input  logic            i_stall,
    // writeback
    input  logic [1:0]      i_wb_we,
    input  logic [4:0]      i_wb_addr0,
    input  logic [4:0]      i_wb_addr1,
    input  logic [XLEN-1:0] i_wb_data0,
    input  logic [XLEN-1:0] i_wb_data1,
    // issue slots a and b
    output logic [1:0]      o_iss_valid,
    output logic [XLEN-1:0] o_iss_pc_a,
    output logic [XLEN-1:0] o_iss_pc_b,
    output op_class_e       o_iss_cls_a,
    output op_class_e       o_iss_cls_b,
    output alu_fn_e         o_iss_alu_fn_a,
    output alu_fn_e         o_iss_alu_fn_b,
    output logic [4:0]      o_iss_rd_a,
    output logic [4:0]      o_iss_rd_b,
    output logic            o_iss_we_a,
    output logic            o_iss_we_b,
    output logic [XLEN-1:0] o_iss_imm_a,
    output logic [XLEN-1:0] o_iss_imm_b,
    output logic [XLEN-1:0] o_iss_src1_a,
    output logic [XLEN-1:0] o_iss_src1_b,
    output logic [XLEN-1:0] o_iss_src2_a,
    output logic [XLEN-1:0] o_iss_src2_b
);

    dec_pkt_t   dec_pkt0;
    dec_pkt_t   dec_pkt1;
    dec_pkt_t   head_pkt0;
    dec_pkt_t   head_pkt1;
    logic [1:0] head_valid;
    logic [1:0] issue_num;

    inst_decoder u_dec0 (.i_inst(i_fetch_inst0), .i_pc(i_fetch_pc0), .o_pkt(dec_pkt0));
    inst_decoder u_dec1 (.i_inst(i_fetch_inst1), .i_pc(i_fetch_pc1), .o_pkt(dec_pkt1));

    issue_queue u_iq (
        .clk          (clk),
        .rstn         (rstn),
        .i_push_valid (i_fetch_valid),
        .i_push_pkt0  (dec_pkt0),
        .i_push_pkt1  (dec_pkt1),
        .i_pop_num    (issue_num), // pop lands on the same edge as issue
        .i_flush      (i_flush),
        .o_head_pkt0  (head_pkt0),
        .o_head_pkt1  (head_pkt1),
        .o_head_valid (head_valid),
        .o_full       (o_iq_full)
    );

    issue_ctrl u_ctrl (
        .i_head_pkt0  (head_pkt0),
        .i_head_pkt1  (head_pkt1),
        .i_head_valid (head_valid),
        .i_stall      (i_stall),
        .o_issue_num  (issue_num)
    );

    reg_file u_rf (
        .clk      (clk),
        .rstn     (rstn),
        .i_raddr0 (head_pkt0.rs1),
        .i_raddr1 (head_pkt0.rs2),
        .i_raddr2 (head_pkt1.rs1),
        .i_raddr3 (head_pkt1.rs2),
        .i_we     (i_wb_we),
        .i_waddr0 (i_wb_addr0),
        .i_waddr1 (i_wb_addr1),
        .i_wdata0 (i_wb_data0),
        .i_wdata1 (i_wb_data1),
        .o_rdata0 (o_iss_src1_a),
        .o_rdata1 (o_iss_src2_a),
        .o_rdata2 (o_iss_src1_b),
        .o_rdata3 (o_iss_src2_b)
    );

    // issue count as a slot mask
    assign o_iss_valid = {issue_num == 2'd2, issue_num != 2'd0};

    assign o_iss_pc_a     = head_pkt0.pc;
    assign o_iss_pc_b     = head_pkt1.pc;
    assign o_iss_cls_a    = head_pkt0.cls;
    assign o_iss_cls_b    = head_pkt1.cls;
    assign o_iss_alu_fn_a = head_pkt0.alu_fn;
    assign o_iss_alu_fn_b = head_pkt1.alu_fn;
    assign o_iss_rd_a     = head_pkt0.rd;
    assign o_iss_rd_b     = head_pkt1.rd;
    assign o_iss_we_a     = head_pkt0.rf_we;
    assign o_iss_we_b     = head_pkt1.rf_we;
    assign o_iss_imm_a    = head_pkt0.imm;
    assign o_iss_imm_b    = head_pkt1.imm;

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`default_nettype none

module reg_file import issue_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic [4:0]      i_raddr0,
    input  logic [4:0]      i_raddr1,
    input  logic [4:0]      i_raddr2,
    input  logic [4:0]      i_raddr3,
    input  logic [1:0]      i_we,
    input  logic [4:0]      i_waddr0,
    input  logic [4:0]      i_waddr1,
    input  logic [XLEN-1:0] i_wdata0,
    input  logic [XLEN-1:0] i_wdata1,
    output logic [XLEN-1:0] o_rdata0,
    output logic [XLEN-1:0] o_rdata1,
    output logic [XLEN-1:0] o_rdata2,
    output logic [XLEN-1:0] o_rdata3
);

    logic [XLEN-1:0] regs [NREG];

    logic wr0_ok;
    logic wr1_ok;

    // writes to x0 are dropped, so regs[0] keeps its reset value
    assign wr0_ok = i_we[0] && (i_waddr0 != 5'd0);
    assign wr1_ok = i_we[1] && (i_waddr1 != 5'd0);

    ////////////////////
    // write ports
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0_ok) begin
                regs[i_waddr0] <= i_wdata0;
            end
            if (wr1_ok) begin
                regs[i_waddr1] <= i_wdata1; // later assignment, port 1 wins a tie
            end
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // no write-through, new value seen the cycle after the edge
    assign o_rdata0 = regs[i_raddr0]; // a rs1
    assign o_rdata1 = regs[i_raddr1]; // a rs2
    assign o_rdata2 = regs[i_raddr2]; // b rs1
    assign o_rdata3 = regs[i_raddr3]; // b rs2

endmodule

`default_nettype wire

// File: hw/issue_ctrl.sv
`default_nettype none

module issue_ctrl import issue_pkg::*; (
    input  dec_pkt_t   i_head_pkt0,
    input  dec_pkt_t   i_head_pkt1,
    input  logic [1:0] i_head_valid,
    input  logic       i_stall,
    output logic [1:0] o_issue_num
);

    logic issue_a;
    logic issue_b;
    logic a_is_mem;
    logic b_is_mem;
    logic mem_pair;     // one memory port downstream
    logic a_branch;
    logic raw_rs1;
    logic raw_rs2;
    logic raw_hazard;

    ////////////////////
    // slot a
    ////////////////////

    assign issue_a = i_head_valid[0] && !i_stall;

    ////////////////////
    // slot b blockers
    ////////////////////

    assign a_is_mem = (i_head_pkt0.cls == cls_load) || (i_head_pkt0.cls == cls_store);
    assign b_is_mem = (i_head_pkt1.cls == cls_load) || (i_head_pkt1.cls == cls_store);
    assign mem_pair = a_is_mem && b_is_mem;

    assign a_branch = (i_head_pkt0.cls == cls_branch); // b may be on the wrong path

    // rd is zeroed by the decoder for non-writers, so rd != 0 covers rf_we
    assign raw_rs1 = (i_head_pkt0.rd != 5'd0) && (i_head_pkt1.rs1 == i_head_pkt0.rd);
    assign raw_rs2 = (i_head_pkt0.rd != 5'd0) && i_head_pkt1.uses_rs2
                     && (i_head_pkt1.rs2 == i_head_pkt0.rd);
    assign raw_hazard = raw_rs1 || raw_rs2; // no forwarding inside a pair

    assign issue_b = issue_a && i_head_valid[1] && !a_branch && !mem_pair && !raw_hazard;

    always_comb begin
        if (issue_b) begin
            o_issue_num = 2'd2;
        end else if (issue_a) begin
            o_issue_num = 2'd1;
        end else begin
            o_issue_num = 2'd0;
        end
    end

    // dcache miss holds the whole pair back
    a_stall_no_issue: assert final (!(i_stall && (o_issue_num != 2'd0)))
        else $error("issue count %0d while stalled", o_issue_num);

endmodule

`default_nettype wire

// File: hw/issue_queue.sv
`default_nettype none

module issue_queue import issue_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic [1:0] i_push_valid,
    input  dec_pkt_t   i_push_pkt0,
    input  dec_pkt_t   i_push_pkt1,
    input  logic [1:0] i_pop_num,
    input  logic       i_flush,
    output dec_pkt_t   o_head_pkt0,
    output dec_pkt_t   o_head_pkt1,
    output logic [1:0] o_head_valid,
    output logic       o_full
);

    dec_pkt_t mem [IQ_DEPTH];

    logic [IQ_PTR_W-1:0] head;       // next write slot
    logic [IQ_PTR_W-1:0] tail;       // oldest entry
    logic [IQ_PTR_W-1:0] head_p1;
    logic [IQ_PTR_W-1:0] tail_p1;
    logic [IQ_PTR_W:0]   count;      // 0..IQ_DEPTH
    logic [IQ_PTR_W:0]   count_nxt;
    logic [1:0]          push_num;
    logic [1:0]          valid_nxt;

    assign push_num = {1'b0, i_push_valid[0]} + {1'b0, i_push_valid[1]};
    assign head_p1  = head + IQ_PTR_W'(1); // depth is a power of two, wraps by itself
    assign tail_p1  = tail + IQ_PTR_W'(1);

    // occupancy once this edge's pushes and pops are applied
    assign count_nxt = count + (IQ_PTR_W+1)'(push_num) - (IQ_PTR_W+1)'(i_pop_num);

    always_comb begin
        if (count_nxt == '0) begin
            valid_nxt = 2'b00;
        end else if (count_nxt == (IQ_PTR_W+1)'(1)) begin
            valid_nxt = 2'b01;
        end else begin
            valid_nxt = 2'b11;
        end
    end

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                mem[i] <= NOP_PKT;
            end
        end else if (!i_flush) begin // flush drops this cycle's fetch
            if (i_push_valid[0]) mem[head]    <= i_push_pkt0;
            if (i_push_valid[1]) mem[head_p1] <= i_push_pkt1;
        end
    end

    ////////////////////
    // pointers, flags
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            o_head_valid <= 2'b00;
            o_full       <= 1'b0;
        end else if (i_flush) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            o_head_valid <= 2'b00;
            o_full       <= 1'b0;
        end else begin
            head         <= head + IQ_PTR_W'(push_num);
            tail         <= tail + IQ_PTR_W'(i_pop_num);
            count        <= count_nxt;
            o_head_valid <= valid_nxt;
            o_full       <= count_nxt >= (IQ_PTR_W+1)'(IQ_DEPTH - IQ_FULL_MARGIN);
        end
    end

    // the two oldest entries, valid or not
    assign o_head_pkt0 = mem[tail];
    assign o_head_pkt1 = mem[tail_p1];

    ////////////////////
    // checks
    ////////////////////

    // controller must not take more than the registered heads offer
    a_pop_le_valid: assert property (@(posedge clk) disable iff (!rstn)
        i_pop_num <= ({1'b0, o_head_valid[1]} + {1'b0, o_head_valid[0]}))
        else $error("pop of %0d with head valid %b", i_pop_num, o_head_valid);

    a_push_in_order: assert property (@(posedge clk) disable iff (!rstn)
        !(i_push_valid[1] && !i_push_valid[0]))
        else $error("fetch slot 1 pushed without slot 0");

    // front end ignoring o_full shows up here a few cycles later
    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= (IQ_PTR_W+1)'(IQ_DEPTH))
        else $error("occupancy %0d over depth", count);

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`default_nettype none

module inst_decoder import issue_pkg::*; (
    input  logic [31:0] i_inst,
    input  logic [31:0] i_pc,
    output dec_pkt_t    o_pkt
);

    opcode_e    opcode;
    logic [4:0] fld_rd;
    logic [4:0] fld_rj;
    logic [4:0] fld_rk;
    op_class_e  cls;
    alu_fn_e    alu_fn;
    logic       rf_we;

    assign opcode = opcode_e'(i_inst[31:28]);
    assign fld_rd = i_inst[27:23];
    assign fld_rj = i_inst[22:18];
    assign fld_rk = i_inst[17:13]; // overlaps imm16, only meaningful for reg-reg ops

    ////////////////////
    // opcode to class
    ////////////////////

    always_comb begin
        cls    = cls_nop;
        alu_fn = fn_add;
        rf_we  = 1'b0;
        case (opcode)
            op_add: begin
                cls   = cls_alu;
                rf_we = 1'b1;
            end
            op_sub: begin
                cls    = cls_alu;
                alu_fn = fn_sub;
                rf_we  = 1'b1;
            end
            op_and: begin
                cls    = cls_alu;
                alu_fn = fn_and;
                rf_we  = 1'b1;
            end
            op_or: begin
                cls    = cls_alu;
                alu_fn = fn_or;
                rf_we  = 1'b1;
            end
            op_addi: begin
                cls   = cls_alu_imm;
                rf_we = 1'b1;
            end
            op_load: begin
                cls   = cls_load;   // address = rj + imm
                rf_we = 1'b1;
            end
            op_store: cls = cls_store;
            op_beq: begin
                cls    = cls_branch;
                alu_fn = fn_sub;    // compare by subtraction
            end
            default: cls = cls_nop; // op_nop and undefined codes
        endcase
    end

    ////////////////////
    // packet fields
    ////////////////////

    always_comb begin
        o_pkt        = NOP_PKT;
        o_pkt.pc     = i_pc;
        o_pkt.cls    = cls;
        o_pkt.alu_fn = alu_fn;
        o_pkt.rf_we  = rf_we;
        o_pkt.rd     = rf_we ? fld_rd : 5'd0;
        o_pkt.rs1    = fld_rj;
        o_pkt.imm    = {{(XLEN-16){i_inst[15]}}, i_inst[15:0]};
        case (cls)
            cls_alu: begin
                o_pkt.rs2      = fld_rk;
                o_pkt.uses_rs2 = 1'b1;
            end
            cls_store, cls_branch: begin
                o_pkt.rs2      = fld_rd; // store data / compare reg lives in rd field
                o_pkt.uses_rs2 = 1'b1;
            end
            default: begin
                o_pkt.rs2      = 5'd0;
                o_pkt.uses_rs2 = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/issue_pkg.sv
`default_nettype none

package issue_pkg;

    ////////////////////
    // sizing
    ////////////////////

    localparam int XLEN           = 32; // data and pc width
    localparam int NREG           = 32; // architectural registers
    localparam int IQ_DEPTH       = 16;
    localparam int IQ_FULL_MARGIN = 4;  // slack for the front end to see o_iq_full
    localparam int IQ_PTR_W       = 4;

    ////////////////////
    // encodings
    ////////////////////

    // instruction bits [31:28]
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_add   = 4'd1,
        op_sub   = 4'd2,
        op_and   = 4'd3,
        op_or    = 4'd4,
        op_addi  = 4'd5,
        op_load  = 4'd6,
        op_store = 4'd7,
        op_beq   = 4'd8
    } opcode_e;

    typedef enum logic [2:0] {
        cls_nop     = 3'd0,
        cls_alu     = 3'd1,
        cls_alu_imm = 3'd2,
        cls_load    = 3'd3,
        cls_store   = 3'd4,
        cls_branch  = 3'd5
    } op_class_e;

    typedef enum logic [1:0] {
        fn_add = 2'd0,
        fn_sub = 2'd1,
        fn_and = 2'd2,
        fn_or  = 2'd3
    } alu_fn_e;

    // one decoded instruction as it sits in the issue queue
    typedef struct packed {
        logic [XLEN-1:0] pc;
        op_class_e       cls;
        alu_fn_e         alu_fn;
        logic [4:0]      rd;       // 0 when rf_we is low
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;      // sign-extended imm16
        logic            rf_we;
        logic            uses_rs2;
    } dec_pkt_t;

    localparam dec_pkt_t NOP_PKT = '{default: '0, cls: cls_nop, alu_fn: fn_add};

endpackage

`default_nettype wire
